/* flist.f */
+incdir+src
src/tile_pkg.sv
src/instrMem.sv
src/dataMem.sv
src/tileCore.sv
src/fabricBridge.sv
src/tileTop.sv
tests/tileTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the tile testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tileTb -f flist.f \
   -Mdir obj_dir -o tileSim \
   && ./obj_dir/tileSim > sim.log 2>&1 \
   || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

/* src/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tile_macros.svh"

module dataMem (
   input  logic                    Clock,
   // port A, core side
   input  logic                    dmAEn,
   input  logic                    dmAWrEn,
   input  logic [`TILE_ADDR_W-1:0] dmAAddr,
   input  logic [31:0]             dmAWrData,
   output logic [31:0]             dmARdData,
   // port B, fabric side
   input  logic                    dmBEn,
   input  logic                    dmBWrEn,
   input  logic [`TILE_ADDR_W-1:0] dmBAddr,
   input  logic [31:0]             dmBWrData,
   output logic [31:0]             dmBRdData
);

logic [31:0] mem [0:`TILE_MEM_DEPTH-1];     // whole-word storage

//============================================================
//      true dual port, read before write
//============================================================
always_ff @(posedge Clock) begin
   if (dmAEn) begin
      dmARdData <= mem[dmAAddr];           // old value on a write
      if (dmAWrEn) begin
         mem[dmAAddr] <= dmAWrData;
      end
   end
   if (dmBEn) begin
      dmBRdData <= mem[dmBAddr];           // returns for fabric read
      if (dmBWrEn) begin
         mem[dmBAddr] <= dmBWrData;        // same addr as A is undefined
      end
   end
end

endmodule

`default_nettype wire

/* src/fabricBridge.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tile_macros.svh"

module fabricBridge
   import tile_pkg::*;
(
   input  logic                    Clock,
   input  logic                    rstN,
   // fabric request
   input  logic                    inFabricValidQ503H,
   input  tFabOp                   inFabricOpQ503H,
   input  logic [15:0]             inFabricAddrQ503H,
   input  logic [31:0]             inFabricDataQ503H,
   output logic                    tileReady,
   // fabric response
   output logic                    outFabricValidQ505H,
   output logic [31:0]             outFabricDataQ505H,
   input  logic                    fabReady,
   // instruction memory write
   output logic                    imWrEn,
   output logic [`TILE_ADDR_W-1:0] imWrAddr,
   output logic [31:0]             imWrData,
   // data memory port B
   output logic                    dmBEn,
   output logic                    dmBWrEn,
   output logic [`TILE_ADDR_W-1:0] dmBAddr,
   output logic [31:0]             dmBWrData,
   input  logic [31:0]             dmBRdData,
   // core start
   output logic                    runPulse,
   output logic [`TILE_ADDR_W-1:0] runPc
);

logic        acceptQ503H;
logic        selDmQ503H;                     // addr bit picks data mem
logic        pendValidQ504H;                 // memory access in flight
logic        pendDmRdQ504H;                  // response is dm read word
logic [31:0] rspDataQ504H;

//============================================================
//      Q503 decode and routing
//============================================================
assign tileReady   = !pendValidQ504H && !outFabricValidQ505H;
assign acceptQ503H = inFabricValidQ503H && tileReady;
assign selDmQ503H  = inFabricAddrQ503H[`TILE_SEL_BIT];

assign imWrEn   = acceptQ503H && (inFabricOpQ503H == fabWrite) && !selDmQ503H;
assign imWrAddr = inFabricAddrQ503H[`TILE_ADDR_W-1:0];
assign imWrData = inFabricDataQ503H;

assign dmBEn     = acceptQ503H && selDmQ503H &&
                   ((inFabricOpQ503H == fabWrite) || (inFabricOpQ503H == fabRead));
assign dmBWrEn   = acceptQ503H && selDmQ503H && (inFabricOpQ503H == fabWrite);
assign dmBAddr   = inFabricAddrQ503H[`TILE_ADDR_W-1:0];
assign dmBWrData = inFabricDataQ503H;

assign runPulse = acceptQ503H && (inFabricOpQ503H == fabRunPc);  // single cycle
assign runPc    = inFabricAddrQ503H[`TILE_ADDR_W-1:0];

// writes, runs and imem reads all answer zero
assign rspDataQ504H = pendDmRdQ504H ? dmBRdData : '0;

//============================================================
//      Q504 pending, Q505 response hold
//============================================================
always_ff @(posedge Clock) begin
   if (!rstN) begin
      pendValidQ504H      <= 1'b0;
      pendDmRdQ504H       <= 1'b0;
      outFabricValidQ505H <= 1'b0;
   end else begin
      pendValidQ504H <= acceptQ503H;
      pendDmRdQ504H  <= acceptQ503H && selDmQ503H && (inFabricOpQ503H == fabRead);
      if (pendValidQ504H) begin
         outFabricValidQ505H <= 1'b1;        // two cycles after accept
      end else if (fabReady) begin
         outFabricValidQ505H <= 1'b0;        // taken by receiver
      end
   end
end

always_ff @(posedge Clock) begin
   if (pendValidQ504H) begin
      outFabricDataQ505H <= rspDataQ504H;    // held under back pressure
   end
end

endmodule

`default_nettype wire

/* src/instrMem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tile_macros.svh"

module instrMem (
   input  logic                    Clock,
   // fabric write port
   input  logic                    imWrEn,
   input  logic [`TILE_ADDR_W-1:0] imWrAddr,
   input  logic [31:0]             imWrData,
   // core fetch port
   input  logic [`TILE_ADDR_W-1:0] imRdAddr,
   output logic [31:0]             imRdData
);

logic [31:0] mem [0:`TILE_MEM_DEPTH-1];     // program store

//============================================================
//      write side, loaded over the fabric
//============================================================
always_ff @(posedge Clock) begin
   if (imWrEn) begin
      mem[imWrAddr] <= imWrData;
   end
end

//============================================================
//      read side
//============================================================
// registered read every cycle, core picks it up in exec
always_ff @(posedge Clock) begin
   imRdData <= mem[imRdAddr];
end

endmodule

`default_nettype wire

/* src/tileCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tile_macros.svh"

module tileCore
   import tile_pkg::*;
(
   input  logic                    Clock,
   input  logic                    rstN,
   input  logic                    runPulse,    // from fabric bridge
   input  logic [`TILE_ADDR_W-1:0] runPc,       // start address
   // instruction memory
   output logic [`TILE_ADDR_W-1:0] imRdAddr,
   input  logic [31:0]             imRdData,    // one cycle after imRdAddr
   // data memory port A
   output logic                    dmAEn,
   output logic                    dmAWrEn,
   output logic [`TILE_ADDR_W-1:0] dmAAddr,
   output logic [31:0]             dmAWrData,
   input  logic [31:0]             dmARdData,   // one cycle after dmAEn
   output logic                    coreHalted
);

tCoreState               state;
logic [`TILE_ADDR_W-1:0] pc;
logic [31:0]             rf [0:`TILE_RF_MSB];  // r0 is a normal reg

tInstr       instr;
tOpcode      op;
logic [31:0] rdVal;
logic [31:0] rsVal;
logic [31:0] immSext;
logic [31:0] memAddr;
logic        isMem;
logic        memIsLoad;                       // latched in exec
logic [3:0]  loadRd;                          // lw target reg

//============================================================
//      decode
//============================================================
assign instr   = tInstr'(imRdData);           // valid in stExec
assign op      = instr.opcode;
assign rdVal   = rf[instr.rd];
assign rsVal   = rf[instr.rs];
assign immSext = {{16{instr.imm[15]}}, instr.imm};
assign memAddr = rsVal + immSext;             // word address, low bits used

assign imRdAddr = pc;                         // fetch always follows pc

// data access only out of exec
assign isMem     = (state == stExec) && ((op == opLw) || (op == opSw));
assign dmAEn     = isMem;
assign dmAWrEn   = isMem && (op == opSw);
assign dmAAddr   = memAddr[`TILE_ADDR_W-1:0];
assign dmAWrData = rdVal;                     // sw stores rd

assign coreHalted = (state == stIdle) || (state == stHalt);

//============================================================
//      control FSM
//============================================================
always_ff @(posedge Clock) begin
   if (!rstN) begin
      state <= stIdle;
      pc    <= '0;
   end else if (runPulse) begin               // restart from any state
      state <= stFetch;
      pc    <= runPc;
   end else begin
      case (state)
         stFetch: begin
            state <= stExec;                  // word comes back next cycle
         end
         stExec: begin
            pc <= pc + 1'b1;                  // default next pc
            case (op)
               opLw, opSw: begin
                  state <= stMemWait;         // one extra cycle
               end
               opBnz: begin
                  state <= stFetch;
                  if (rdVal != '0) begin
                     pc <= instr.imm[`TILE_ADDR_W-1:0];  // taken
                  end
               end
               opHalt: begin
                  state <= stHalt;
                  pc    <= pc;                // park on the halt
               end
               default: begin
                  state <= stFetch;           // nop, li, add, sub
               end
            endcase
         end
         stMemWait: begin
            state <= stFetch;
         end
         default: begin
            state <= state;                   // idle and halt wait for run
         end
      endcase
   end
end

//============================================================
//      register file
//============================================================
always_ff @(posedge Clock) begin
   if (state == stExec) begin
      memIsLoad <= (op == opLw);
      loadRd    <= instr.rd;
      case (op)
         opLi:    rf[instr.rd] <= immSext;
         opAdd:   rf[instr.rd] <= rdVal + rsVal;
         opSub:   rf[instr.rd] <= rdVal - rsVal;
         default: ;                           // no reg write
      endcase
   end
   if ((state == stMemWait) && memIsLoad) begin
      rf[loadRd] <= dmARdData;                // lw writeback
   end
end

endmodule

`default_nettype wire

/* src/tileTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tile_macros.svh"

module tileTop
   import tile_pkg::*;
(
   input  logic        Clock,
   input  logic        rstN,
   //============================================================
   //      fabric interface
   //============================================================
   input  logic        inFabricValidQ503H,
   input  tFabOp       inFabricOpQ503H,
   input  logic [15:0] inFabricAddrQ503H,
   input  logic [31:0] inFabricDataQ503H,
   output logic        tileReady,          // bridge idle
   output logic        outFabricValidQ505H,
   output logic [31:0] outFabricDataQ505H,
   input  logic        fabReady,           // receiver takes response
   output logic        coreHalted
);

logic                    imWrEn;           // bridge to imem
logic [`TILE_ADDR_W-1:0] imWrAddr;
logic [31:0]             imWrData;
logic [`TILE_ADDR_W-1:0] imRdAddr;         // core fetch
logic [31:0]             imRdData;
logic                    dmAEn;            // core to dmem A
logic                    dmAWrEn;
logic [`TILE_ADDR_W-1:0] dmAAddr;
logic [31:0]             dmAWrData;
logic [31:0]             dmARdData;
logic                    dmBEn;            // bridge to dmem B
logic                    dmBWrEn;
logic [`TILE_ADDR_W-1:0] dmBAddr;
logic [31:0]             dmBWrData;
logic [31:0]             dmBRdData;
logic                    runPulse;         // bridge to core
logic [`TILE_ADDR_W-1:0] runPc;

tileCore tileCore (
   .Clock      (Clock),      .rstN       (rstN),
   .runPulse   (runPulse),   .runPc      (runPc),
   .imRdAddr   (imRdAddr),   .imRdData   (imRdData),
   .dmAEn      (dmAEn),      .dmAWrEn    (dmAWrEn),
   .dmAAddr    (dmAAddr),    .dmAWrData  (dmAWrData),
   .dmARdData  (dmARdData),  .coreHalted (coreHalted)
);

instrMem instrMem (
   .Clock    (Clock),
   .imWrEn   (imWrEn),   .imWrAddr (imWrAddr), .imWrData (imWrData),
   .imRdAddr (imRdAddr), .imRdData (imRdData)
);

dataMem dataMem (
   .Clock     (Clock),
   .dmAEn     (dmAEn),     .dmAWrEn   (dmAWrEn),   .dmAAddr   (dmAAddr),
   .dmAWrData (dmAWrData), .dmARdData (dmARdData),
   .dmBEn     (dmBEn),     .dmBWrEn   (dmBWrEn),   .dmBAddr   (dmBAddr),
   .dmBWrData (dmBWrData), .dmBRdData (dmBRdData)
);

fabricBridge fabricBridge (
   .Clock               (Clock),               .rstN               (rstN),
   .inFabricValidQ503H  (inFabricValidQ503H),  .inFabricOpQ503H    (inFabricOpQ503H),
   .inFabricAddrQ503H   (inFabricAddrQ503H),   .inFabricDataQ503H  (inFabricDataQ503H),
   .tileReady           (tileReady),           .fabReady           (fabReady),
   .outFabricValidQ505H (outFabricValidQ505H), .outFabricDataQ505H (outFabricDataQ505H),
   .imWrEn   (imWrEn),   .imWrAddr  (imWrAddr),  .imWrData  (imWrData),
   .dmBEn    (dmBEn),    .dmBWrEn   (dmBWrEn),   .dmBAddr   (dmBAddr),
   .dmBWrData (dmBWrData), .dmBRdData (dmBRdData),
   .runPulse (runPulse), .runPc     (runPc)
);

endmodule

`default_nettype wire

/* src/tile_macros.svh */
`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

//============================================================
//      tile sizing
//============================================================
`define TILE_MEM_DEPTH 256   // words in each memory
`define TILE_ADDR_W    8     // word address width
`define TILE_RF_MSB    15    // 16 regs, rv32e sized

// fabric address bit, set = data mem, clear = instr mem
`define TILE_SEL_BIT   14

`endif

/* src/tile_pkg.sv */
`default_nettype none

package tile_pkg;

   //============================================================
   //      core instruction set
   //============================================================
   typedef enum logic [3:0] {
      opNop  = 4'h0,    // no operation
      opLi   = 4'h1,    // rd = sext(imm)
      opAdd  = 4'h2,    // rd = rd + rs
      opSub  = 4'h3,    // rd = rd - rs
      opLw   = 4'h4,    // rd = dMem[rs + imm]
      opSw   = 4'h5,    // dMem[rs + imm] = rd
      opBnz  = 4'h6,    // rd != 0 -> pc = imm
      opHalt = 4'h7     // stop, wait for run
   } tOpcode;

   // five states, so three bits
   typedef enum logic [2:0] {
      stIdle,           // out of reset
      stFetch,          // pc on fetch address
      stExec,           // instruction word valid
      stMemWait,        // load data returning
      stHalt            // stopped by opHalt
   } tCoreState;

   //============================================================
   //      fabric side
   //============================================================
   typedef enum logic [1:0] {
      fabWrite = 2'd0,  // write either memory
      fabRead  = 2'd1,  // read, data mem only
      fabRunPc = 2'd2   // restart core at addr
   } tFabOp;

   typedef struct packed {
      tOpcode      opcode;  // [31:28]
      logic [3:0]  rd;      // [27:24]
      logic [3:0]  rs;      // [23:20]
      logic [3:0]  spare;   // [19:16] ignored
      logic [15:0] imm;     // [15:0]
   } tInstr;

endpackage

`default_nettype wire

/* tests/tileTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tile_macros.svh"

module tileTb
   import tile_pkg::*;
();

localparam int NumRows = 4;
localparam int Timeout = 200;              // cycles per wait loop

logic        Clock;
logic        rstN;
logic        inFabricValidQ503H;
tFabOp       inFabricOpQ503H;
logic [15:0] inFabricAddrQ503H;
logic [31:0] inFabricDataQ503H;
logic        tileReady;
logic        outFabricValidQ505H;
logic [31:0] outFabricDataQ505H;
logic        fabReady;
logic        coreHalted;

int   errCount;
int   checkCount;
logic timedOut;                            // a wait loop ran out

// stimulus table, one program per row
logic [31:0] progWords [NumRows][8];
int          progLen   [NumRows];
logic [7:0]  startPc   [NumRows];
logic        preEn     [NumRows];      // preload a data word first
logic [7:0]  preAddr   [NumRows];
logic [31:0] preData   [NumRows];
logic [7:0]  resAddr   [NumRows];
logic [31:0] expWord   [NumRows];      // worked out by hand

tileTop dut (
   .Clock               (Clock),
   .rstN                (rstN),
   .inFabricValidQ503H  (inFabricValidQ503H),
   .inFabricOpQ503H     (inFabricOpQ503H),
   .inFabricAddrQ503H   (inFabricAddrQ503H),
   .inFabricDataQ503H   (inFabricDataQ503H),
   .tileReady           (tileReady),
   .outFabricValidQ505H (outFabricValidQ505H),
   .outFabricDataQ505H  (outFabricDataQ505H),
   .fabReady            (fabReady),
   .coreHalted          (coreHalted)
);

always #2 Clock = ~Clock;                  // 4 ns period

//============================================================
//      helpers
//============================================================
function automatic logic [31:0] encode(input tOpcode op, input logic [3:0] rd,
                                       input logic [3:0] rs, input logic [15:0] imm);
   tInstr word;
   word.opcode = op;
   word.rd     = rd;
   word.rs     = rs;
   word.spare  = 4'h0;
   word.imm    = imm;
   return word;
endfunction

function automatic logic [15:0] dataAddr(input logic [7:0] wordAddr);
   logic [15:0] a;
   a = {8'h00, wordAddr};
   a[`TILE_SEL_BIT] = 1'b1;                // steer to data mem
   return a;
endfunction

task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
   checkCount++;
   if (act !== exp) begin
      errCount++;
      $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
   end
endtask

task automatic noteTimeout(input string why);
   timedOut = 1'b1;
   errCount++;
   $display("timeout at %0t ns: %s", $time, why);
endtask

// one request, one response, with random back pressure
task automatic fabricXfer(input tFabOp op, input logic [15:0] addr,
                          input logic [31:0] data, output logic [31:0] rsp);
   int          waitCnt;
   int          holdCycles;
   int          i;
   logic [31:0] firstData;
   rsp     = '0;
   waitCnt = 0;
   if (timedOut) return;                   // tile already stuck
   @(negedge Clock);
   while (!tileReady && waitCnt < Timeout) begin
      @(negedge Clock);
      waitCnt++;
   end
   if (!tileReady) begin
      noteTimeout("tileReady stayed low");
      return;
   end
   @(posedge Clock);
   inFabricValidQ503H <= 1'b1;
   inFabricOpQ503H    <= op;
   inFabricAddrQ503H  <= addr;
   inFabricDataQ503H  <= data;
   fabReady           <= 1'b0;         // hold off the response
   @(posedge Clock);                       // taken on this edge
   inFabricValidQ503H <= 1'b0;
   @(negedge Clock);
   checkValue("tileReady", 32'd0, tileReady);
   waitCnt = 0;
   while (!outFabricValidQ505H && waitCnt < Timeout) begin
      @(negedge Clock);
      waitCnt++;
   end
   if (!outFabricValidQ505H) begin
      noteTimeout("no response from tile");
      return;
   end
   checkValue("response latency", 32'd1, waitCnt);
   firstData  = outFabricDataQ505H;
   holdCycles = $urandom % 4;              // 0 to 3 stalled cycles
   for (i = 0; i < holdCycles; i++) begin
      @(negedge Clock);
      checkValue("outFabricValidQ505H", 32'd1, outFabricValidQ505H);
      checkValue("outFabricDataQ505H", firstData, outFabricDataQ505H);
      checkValue("tileReady", 32'd0, tileReady);
   end
   @(posedge Clock);
   fabReady <= 1'b1;
   @(posedge Clock);                       // response taken here
   @(negedge Clock);
   checkValue("outFabricValidQ505H", 32'd0, outFabricValidQ505H);
   rsp = firstData;
endtask

task automatic waitHalt();
   int waitCnt;
   waitCnt = 0;
   if (timedOut) return;
   @(negedge Clock);
   while (!coreHalted && waitCnt < Timeout) begin
      @(negedge Clock);
      waitCnt++;
   end
   if (!coreHalted) noteTimeout("core never halted");
endtask

//============================================================
//      stimulus table
//============================================================
task automatic buildTable();
   // 7 + 20 = 27, minus -4 = 31
   progWords[0] = '{encode(opLi, 1, 0, 16'd7),    encode(opLi, 2, 0, 16'd20),
                    encode(opAdd, 1, 2, 0),       encode(opLi, 3, 0, 16'hfffc),
                    encode(opSub, 1, 3, 0),       encode(opLi, 0, 0, 0),
                    encode(opSw, 1, 0, 16'h0010), encode(opHalt, 0, 0, 0)};
   // 5 + 4 + 3 + 2 + 1, r1 ends at zero
   progWords[1] = '{encode(opLi, 1, 0, 16'd5),    encode(opLi, 2, 0, 16'd0),
                    encode(opLi, 3, 0, 16'd1),    encode(opAdd, 2, 1, 0),
                    encode(opSub, 1, 3, 0),       encode(opBnz, 1, 0, 16'h0023),
                    encode(opSw, 2, 1, 16'h0011), encode(opHalt, 0, 0, 0)};
   // load word at 0x30, add 0x101, store at 0x31
   progWords[2] = '{encode(opLi, 5, 0, 16'h0020), encode(opLw, 6, 5, 16'h0010),
                    encode(opLi, 7, 0, 16'h0101), encode(opAdd, 6, 7, 0),
                    encode(opSw, 6, 5, 16'h0011), encode(opHalt, 0, 0, 0), 0, 0};
   // branch not taken, nop, negative li
   progWords[3] = '{encode(opLi, 8, 0, 16'h0000), encode(opBnz, 8, 0, 16'h0060),
                    encode(opNop, 0, 0, 0),       encode(opLi, 9, 0, 16'hffff),
                    encode(opSw, 9, 8, 16'h0012), encode(opHalt, 0, 0, 0), 0, 0};
   progLen = '{8, 8, 6, 6};
   startPc = '{8'h00, 8'h20, 8'h40, 8'h60};
   preEn   = '{1'b0, 1'b0, 1'b1, 1'b0};
   preAddr = '{8'h00, 8'h00, 8'h30, 8'h00};
   preData = '{32'h0, 32'h0, 32'h1234_0000, 32'h0};
   resAddr = '{8'h10, 8'h11, 8'h31, 8'h12};
   expWord = '{32'd31, 32'd15, 32'h1234_0101, 32'hffff_ffff};
endtask

//============================================================
//      main sequence
//============================================================
initial begin
   logic [31:0] rsp;
   int          row;
   int          k;
   void'($urandom(32'h8999_db56));
   errCount           = 0;
   checkCount         = 0;
   timedOut           = 1'b0;
   Clock              = 1'b0;
   rstN               = 1'b0;
   inFabricValidQ503H = 1'b0;
   inFabricOpQ503H    = fabWrite;
   inFabricAddrQ503H  = '0;
   inFabricDataQ503H  = '0;
   fabReady           = 1'b0;
   buildTable();
   repeat (3) @(posedge Clock);            // three reset edges
   rstN <= 1'b1;
   @(negedge Clock);
   checkValue("tileReady", 32'd1, tileReady);
   checkValue("coreHalted", 32'd1, coreHalted);
   checkValue("outFabricValidQ505H", 32'd0, outFabricValidQ505H);

   // data mem round trip, imem read answers zero
   fabricXfer(fabWrite, dataAddr(8'h50), 32'ha5a5_5a5a, rsp);
   checkValue("outFabricDataQ505H write", 32'h0, rsp);
   fabricXfer(fabRead, dataAddr(8'h50), 32'h0, rsp);
   checkValue("outFabricDataQ505H read", 32'ha5a5_5a5a, rsp);
   fabricXfer(fabRead, 16'h0003, 32'h0, rsp);
   checkValue("outFabricDataQ505H imem read", 32'h0, rsp);

   for (row = 0; row < NumRows && !timedOut; row++) begin
      if (preEn[row]) begin
         fabricXfer(fabWrite, dataAddr(preAddr[row]), preData[row], rsp);
         checkValue("outFabricDataQ505H preload", 32'h0, rsp);
      end
      for (k = 0; k < progLen[row]; k++) begin
         fabricXfer(fabWrite, {8'h00, startPc[row] + 8'(k)}, progWords[row][k], rsp);
         checkValue("outFabricDataQ505H imem write", 32'h0, rsp);
      end
      fabricXfer(fabRunPc, {8'h00, startPc[row]}, 32'h0, rsp);
      checkValue("outFabricDataQ505H run", 32'h0, rsp);
      checkValue("coreHalted", 32'd0, coreHalted);   // run clears halt
      waitHalt();
      fabricXfer(fabRead, dataAddr(resAddr[row]), 32'h0, rsp);
      checkValue($sformatf("outFabricDataQ505H row %0d", row), expWord[row], rsp);
   end

   $display("checks %0d, errors %0d", checkCount, errCount);
   if (errCount == 0) begin
      $display("sim passed");
   end else begin
      $display("sim failed");
   end
   $finish;
end

endmodule

`default_nettype wire
